// ==== source/rate_limiter_pkg.sv ====
// Packet rate limiter shared definitions
// Stream widths, the FIFO payload word and the gap timer sizes

package rate_limiter_pkg;

  // Stream data path
  localparam int data_width = 64;
  // One strobe bit per byte
  localparam int strb_width = data_width / 8;
  // Sideband carried with every word
  localparam int user_width = 16;

  // Gap timer sizing
  // Width of the rate_shift input, shifts 0 to 15
  localparam int shift_width = 4;
  // Word counter and gap countdown share this width
  // Packet length shifted left by 15 must still fit
  localparam int count_width = 32;

  // One stream beat as stored in the FIFO
  // Field order follows the bus signal order
  typedef struct packed {
    logic [data_width-1:0] tdata;
    logic [strb_width-1:0] tstrb;
    logic [user_width-1:0] tuser;
    logic                  tlast;
  } axis_word_t;

endpackage

// ==== source/axis_if.sv ====
// AXI-Stream link between blocks of the rate limiter
// Carries one packed stream word with a valid/ready handshake
// A beat moves on a rising clock edge with valid and ready both high

`timescale 1ns/1ps

interface axis_if;

  // Whole beat, data plus sideband plus tlast
  rate_limiter_pkg::axis_word_t word;
  // Producer has a beat on word
  logic                         valid;
  // Consumer can take the beat this cycle
  logic                         ready;

  // Producer side
  // Holds word steady while valid is high and not yet taken
  modport source (
    output word,
    output valid,
    input  ready
  );

  // Consumer side
  modport sink (
    input  word,
    input  valid,
    output ready
  );

endinterface

// ==== source/stream_fifo.sv ====
// Small fall-through stream FIFO
// Circular buffer of 2**depth_bits entries, head visible with no read delay
// Input ready drops at depth minus one entries, the nearly-full margin

`timescale 1ns/1ps

module stream_fifo #(
  parameter type payload_t  = logic,
  parameter int  depth_bits = 2
) (
  input  logic  axi_aclk,
  input  logic  arst_n,
  input  logic  sw_rst,
  axis_if.sink   wr,
  axis_if.source rd
);

  // Payload storage
  payload_t mem [2**depth_bits];

  // Pointers wrap naturally at the power of two
  logic [depth_bits-1:0] wr_ptr;
  logic [depth_bits-1:0] rd_ptr;
  // One extra bit so a full buffer is distinct from empty
  logic [depth_bits:0]   count;

  logic push;
  logic pop;

  // Handshakes on both sides
  assign push = wr.valid && wr.ready;
  assign pop  = rd.valid && rd.ready;

  // Nearly full once depth minus one entries are held
  // Leaves one slot of slack for the upstream source
  assign wr.ready = (count < (depth_bits + 1)'(2**depth_bits - 1));

  // Fall-through head
  assign rd.valid = (count != '0);
  assign rd.word  = mem[rd_ptr];

  // Payload write
  always_ff @(posedge axi_aclk) begin
    if (push) begin
      mem[wr_ptr] <= wr.word;
    end
  end

  // Pointer and occupancy control
  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (sw_rst) begin
      // Soft reset drops everything buffered
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves count unchanged
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== source/gap_timer.sv ====
// Inter-packet gap timer
// Counts the words of the current packet, then closes the gap for
// packet length shifted left by rate_shift cycles

`timescale 1ns/1ps

module gap_timer (
  input  logic                                   axi_aclk,
  input  logic                                   arst_n,
  input  logic                                   sw_rst,
  input  logic [rate_limiter_pkg::shift_width-1:0] rate_shift,
  input  logic                                   word_taken,
  input  logic                                   last_taken,
  output logic                                   gap_open
);

  // Counting packet words, or waiting out the gap
  typedef enum logic {
    st_count,
    st_gap
  } state_t;

  state_t state;
  state_t state_nxt;

  // Word count while counting, remaining idle cycles while in the gap
  logic [rate_limiter_pkg::count_width-1:0] count;
  logic [rate_limiter_pkg::count_width-1:0] count_nxt;

  // Gap open only in the counting state
  assign gap_open = (state == st_count);

  // Next state and counter
  always_comb begin
    state_nxt = state;
    count_nxt = count;
    case (state)
      st_count: begin
        if (last_taken) begin
          // k words before the last, so k+1 is the packet length
          count_nxt = (count + 1'b1) << rate_shift;
          state_nxt = st_gap;
        end else if (word_taken) begin
          count_nxt = count + 1'b1;
        end
      end
      st_gap: begin
        if (count > 1) begin
          count_nxt = count - 1'b1;
        end else begin
          // Gap served, open again on the next cycle
          count_nxt = '0;
          state_nxt = st_count;
        end
      end
      default: begin
        state_nxt = st_count;
        count_nxt = '0;
      end
    endcase
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_count;
      count <= '0;
    end else if (sw_rst) begin
      // No gap owed after a soft reset
      state <= st_count;
      count <= '0;
    end else begin
      state <= state_nxt;
      count <= count_nxt;
    end
  end

endmodule

// ==== source/egress_gate.sv ====
// Egress gate of the rate limiter
// Shows the FIFO head on the output while the gap is open and
// pulses word and last-word strobes to the gap timer on each handshake

`timescale 1ns/1ps

module egress_gate (
  input  logic                         axi_aclk,
  input  logic                         arst_n,
  input  logic                         gap_open,
  axis_if.sink                         head,
  output rate_limiter_pkg::axis_word_t out_word,
  output logic                         out_valid,
  input  logic                         out_ready,
  output logic                         word_taken,
  output logic                         last_taken
);

  // Set between the first and last word of a packet
  logic in_pkt;
  // Head may go out this cycle
  logic pass;
  // Output handshake
  logic fire;

  // Gap only matters at a packet start
  // Keeps a packet whole whatever the timer does
  assign pass = in_pkt || gap_open;

  // Head payload goes straight out
  assign out_word = head.word;

  // Valid only when allowed to pass
  assign out_valid = head.valid && pass;

  // Pop the FIFO only on an accepted beat
  assign head.ready = out_ready && pass;

  assign fire = head.valid && out_ready && pass;

  // Strobes to the timer, one cycle each
  assign word_taken = fire;
  assign last_taken = fire && head.word.tlast;

  // Packet-in-progress tracking
  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      in_pkt <= 1'b0;
    end else if (fire) begin
      // Last word closes the packet, any other word opens or extends it
      in_pkt <= !head.word.tlast;
    end
  end

endmodule

// ==== source/rate_limiter.sv ====
// Packet rate limiter for a 64-bit AXI-Stream path
// Enabled, each packet of n words is followed by n << rate_shift idle cycles
// Disabled, the stream is passed straight through with no storage

`timescale 1ns/1ps

module rate_limiter (
  input  logic                                     axi_aclk,
  input  logic                                     arst_n,
  input  logic                                     sw_rst,
  input  logic                                     rate_en,
  input  logic [rate_limiter_pkg::shift_width-1:0] rate_shift,

  // Sink side, from upstream
  input  logic [rate_limiter_pkg::data_width-1:0]  s_tdata,
  input  logic [rate_limiter_pkg::strb_width-1:0]  s_tstrb,
  input  logic [rate_limiter_pkg::user_width-1:0]  s_tuser,
  input  logic                                     s_tlast,
  input  logic                                     s_tvalid,
  output logic                                     s_tready,

  // Source side, to downstream
  output logic [rate_limiter_pkg::data_width-1:0]  m_tdata,
  output logic [rate_limiter_pkg::strb_width-1:0]  m_tstrb,
  output logic [rate_limiter_pkg::user_width-1:0]  m_tuser,
  output logic                                     m_tlast,
  output logic                                     m_tvalid,
  input  logic                                     m_tready
);

  // Links between the internal blocks
  axis_if fifo_in_if ();
  axis_if fifo_out_if ();

  // Gate output toward the m_ ports
  rate_limiter_pkg::axis_word_t gate_word;
  logic                         gate_valid;

  // Timer strobes and gap state
  logic word_taken;
  logic last_taken;
  logic gap_open;

  // Pack the sink side into one payload word
  assign fifo_in_if.word.tdata = s_tdata;
  assign fifo_in_if.word.tstrb = s_tstrb;
  assign fifo_in_if.word.tuser = s_tuser;
  assign fifo_in_if.word.tlast = s_tlast;
  // No writes while bypassed
  assign fifo_in_if.valid      = s_tvalid && rate_en;

  // Payload buffer
  stream_fifo #(
    .payload_t  (rate_limiter_pkg::axis_word_t),
    .depth_bits (2)
  ) fifo_i (
    .axi_aclk (axi_aclk),
    .arst_n   (arst_n),
    .sw_rst   (sw_rst),
    .wr       (fifo_in_if.sink),
    .rd       (fifo_out_if.source)
  );

  // Inter-packet gap timing
  gap_timer timer_i (
    .axi_aclk   (axi_aclk),
    .arst_n     (arst_n),
    .sw_rst     (sw_rst),
    .rate_shift (rate_shift),
    .word_taken (word_taken),
    .last_taken (last_taken),
    .gap_open   (gap_open)
  );

  // Head of FIFO to output, held back during the gap
  // Downstream ready only reaches it in limited mode
  egress_gate gate_i (
    .axi_aclk   (axi_aclk),
    .arst_n     (arst_n),
    .gap_open   (gap_open),
    .head       (fifo_out_if.sink),
    .out_word   (gate_word),
    .out_valid  (gate_valid),
    .out_ready  (m_tready && rate_en),
    .word_taken (word_taken),
    .last_taken (last_taken)
  );

  // Output select, bypass or limited path
  always_comb begin
    if (rate_en) begin
      m_tdata  = gate_word.tdata;
      m_tstrb  = gate_word.tstrb;
      m_tuser  = gate_word.tuser;
      m_tlast  = gate_word.tlast;
      m_tvalid = gate_valid;
      // Back-pressure from the FIFO nearly-full flag
      s_tready = fifo_in_if.ready;
    end else begin
      // Zero-latency straight path
      m_tdata  = s_tdata;
      m_tstrb  = s_tstrb;
      m_tuser  = s_tuser;
      m_tlast  = s_tlast;
      m_tvalid = s_tvalid;
      s_tready = m_tready;
    end
  end

endmodule

// ==== tests/rate_limiter_tb.sv ====
// Directed testbench for the packet rate limiter
// Runs bypass, data integrity, gap length, back-pressure and soft reset tests
// A rising-edge monitor keeps the scoreboard and measures inter-packet gaps

`timescale 1ns/1ps

module rate_limiter_tb;

  // About 90 words at up to 1 + 2**3 cycles each, plus reset and drain margin
  localparam int max_cycles = 4000;
  // Longest wait for one input handshake or for the output to drain
  localparam int wait_limit = 200;

  logic                                     axi_aclk;
  logic                                     arst_n;
  logic                                     sw_rst;
  logic                                     rate_en;
  logic [rate_limiter_pkg::shift_width-1:0] rate_shift;
  logic [rate_limiter_pkg::data_width-1:0]  s_tdata;
  logic [rate_limiter_pkg::strb_width-1:0]  s_tstrb;
  logic [rate_limiter_pkg::user_width-1:0]  s_tuser;
  logic                                     s_tlast;
  logic                                     s_tvalid;
  logic                                     s_tready;
  logic [rate_limiter_pkg::data_width-1:0]  m_tdata;
  logic [rate_limiter_pkg::strb_width-1:0]  m_tstrb;
  logic [rate_limiter_pkg::user_width-1:0]  m_tuser;
  logic                                     m_tlast;
  logic                                     m_tvalid;
  logic                                     m_tready;

  // Words sent but not yet seen on the output
  rate_limiter_pkg::axis_word_t exp_q[$];
  // Idle output cycles measured after each last word
  int gap_q[$];

  int cycle = 0;
  int err_count = 0;
  int test_errs = 0;
  int pass_count = 0;
  int fail_count = 0;
  // Input handshakes into the limited path
  int wr_count = 0;
  int idle_run = 0;
  logic gap_wait = 1'b0;
  // Output word seen stalled on the previous edge
  logic held_valid = 1'b0;
  rate_limiter_pkg::axis_word_t held_word;

  rate_limiter dut_i (
    .axi_aclk   (axi_aclk),
    .arst_n     (arst_n),
    .sw_rst     (sw_rst),
    .rate_en    (rate_en),
    .rate_shift (rate_shift),
    .s_tdata    (s_tdata),
    .s_tstrb    (s_tstrb),
    .s_tuser    (s_tuser),
    .s_tlast    (s_tlast),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .m_tdata    (m_tdata),
    .m_tstrb    (m_tstrb),
    .m_tuser    (m_tuser),
    .m_tlast    (m_tlast),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready)
  );

  // 40 ns clock
  initial axi_aclk = 1'b0;
  always #20 axi_aclk = ~axi_aclk;

  task automatic report_mismatch(input string name, input logic [63:0] expv,
                                 input logic [63:0] gotv);
    $display("** Error: %s expected %h, got %h at cycle %0d", name, expv, gotv, cycle);
    err_count++;
  endtask

  task automatic report_failure(input string msg);
    $display("Error: %s at cycle %0d", msg, cycle);
    err_count++;
  endtask

  function automatic rate_limiter_pkg::axis_word_t random_word(input logic last);
    rate_limiter_pkg::axis_word_t w;
    logic [31:0] r;
    w.tdata = {$urandom(), $urandom()};
    r = $urandom();
    w.tstrb = r[7:0];
    w.tuser = r[31:16];
    w.tlast = last;
    return w;
  endfunction

  function automatic rate_limiter_pkg::axis_word_t output_word();
    rate_limiter_pkg::axis_word_t w;
    w.tdata = m_tdata;
    w.tstrb = m_tstrb;
    w.tuser = m_tuser;
    w.tlast = m_tlast;
    return w;
  endfunction

  task automatic compare_word(input rate_limiter_pkg::axis_word_t expw,
                              input rate_limiter_pkg::axis_word_t gotw);
    if (gotw.tdata !== expw.tdata) report_mismatch("m_tdata", expw.tdata, gotw.tdata);
    if (gotw.tstrb !== expw.tstrb) report_mismatch("m_tstrb", expw.tstrb, gotw.tstrb);
    if (gotw.tuser !== expw.tuser) report_mismatch("m_tuser", expw.tuser, gotw.tuser);
    if (gotw.tlast !== expw.tlast) report_mismatch("m_tlast", expw.tlast, gotw.tlast);
  endtask

  // Scoreboard, stall hold check and gap measurement on each edge
  task automatic sample_output();
    rate_limiter_pkg::axis_word_t got;
    got = output_word();
    if (rate_en && s_tvalid && s_tready) wr_count++;
    // A stalled word must stay put
    if (held_valid && rate_en && !sw_rst) begin
      if (!m_tvalid) report_failure("m_tvalid dropped before its word was taken");
      else compare_word(held_word, got);
    end
    // Idle run after a last word ends at the next valid
    if (gap_wait) begin
      if (m_tvalid) begin
        gap_q.push_back(idle_run);
        gap_wait = 1'b0;
      end else begin
        idle_run++;
      end
    end
    if (m_tvalid && m_tready) begin
      if (exp_q.size() == 0) report_failure("output word appeared with none expected");
      else compare_word(exp_q.pop_front(), got);
      if (m_tlast) begin
        gap_wait = 1'b1;
        idle_run = 0;
      end
    end
    held_valid = rate_en && m_tvalid && !m_tready;
    held_word  = got;
  endtask

  always @(posedge axi_aclk) begin
    cycle++;
    if (cycle >= max_cycles) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycle);
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      sample_output();
    end
  end

  task automatic apply_word(input rate_limiter_pkg::axis_word_t w);
    s_tdata  = w.tdata;
    s_tstrb  = w.tstrb;
    s_tuser  = w.tuser;
    s_tlast  = w.tlast;
    s_tvalid = 1'b1;
  endtask

  // One word on the sink side, held until accepted
  task automatic drive_word(input rate_limiter_pkg::axis_word_t w);
    int n;
    n = 0;
    @(negedge axi_aclk);
    apply_word(w);
    exp_q.push_back(w);
    @(posedge axi_aclk);
    while (!s_tready && n < wait_limit) begin
      @(posedge axi_aclk);
      n++;
    end
    if (!s_tready) report_failure("input word was never accepted");
  endtask

  task automatic send_packet(input int len);
    for (int i = 0; i < len; i++) begin
      drive_word(random_word(i == len - 1));
    end
  endtask

  task automatic go_idle();
    @(negedge axi_aclk);
    s_tvalid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < wait_limit) begin
      @(negedge axi_aclk);
      n++;
    end
    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d words never reached the output", exp_q.size()));
      exp_q.delete();
    end
  endtask

  task automatic begin_test();
    test_errs = err_count;
  endtask

  task automatic end_test(input string name);
    if (err_count == test_errs) begin
      $display("%s: passed", name);
      pass_count++;
    end else begin
      $display("%s: failed with %0d errors", name, err_count - test_errs);
      fail_count++;
    end
  endtask

  // Straight wire, ready toggled at random
  task automatic test_bypass();
    rate_limiter_pkg::axis_word_t w;
    logic [31:0] r;
    logic taken;
    begin_test();
    for (int i = 0; i < 20; i++) begin
      w = random_word(i % 5 == 4);
      exp_q.push_back(w);
      taken = 1'b0;
      while (!taken) begin
        @(negedge axi_aclk);
        apply_word(w);
        r = $urandom();
        m_tready = r[0];
        #1;
        compare_word(w, output_word());
        if (m_tvalid !== 1'b1) report_mismatch("m_tvalid", 1, m_tvalid);
        if (s_tready !== m_tready) report_mismatch("s_tready", m_tready, s_tready);
        taken = m_tready;
      end
    end
    go_idle();
    m_tready = 1'b1;
    #1;
    if (m_tvalid !== 1'b0) report_mismatch("m_tvalid", 0, m_tvalid);
    wait_drain();
    end_test("bypass");
  endtask

  task automatic test_integrity();
    begin_test();
    @(negedge axi_aclk);
    rate_en    = 1'b1;
    rate_shift = '0;
    m_tready   = 1'b1;
    #1;
    // FIFO empty since reset
    if (s_tready !== 1'b1) report_mismatch("s_tready", 1, s_tready);
    if (m_tvalid !== 1'b0) report_mismatch("m_tvalid", 0, m_tvalid);
    for (int n = 1; n <= 6; n++) begin
      send_packet(n);
    end
    go_idle();
    wait_drain();
    end_test("integrity");
  endtask

  task automatic test_gap_length();
    int shifts[3] = '{0, 1, 3};
    begin_test();
    for (int k = 0; k < 3; k++) begin
      @(negedge axi_aclk);
      rate_shift = shifts[k][rate_limiter_pkg::shift_width-1:0];
      gap_q.delete();
      gap_wait = 1'b0;
      send_packet(1);
      send_packet(4);
      send_packet(5);
      go_idle();
      wait_drain();
      // Gaps after the 1-word and the 4-word packets
      if (gap_q.size() != 2) begin
        report_failure($sformatf("%0d gaps measured instead of 2", gap_q.size()));
      end else begin
        if (gap_q[0] != (1 << shifts[k])) begin
          report_mismatch("m_tvalid idle cycles", 1 << shifts[k], gap_q[0]);
        end
        if (gap_q[1] != (4 << shifts[k])) begin
          report_mismatch("m_tvalid idle cycles", 4 << shifts[k], gap_q[1]);
        end
      end
    end
    end_test("gap length");
  endtask

  task automatic test_back_pressure();
    int n;
    int wr_start;
    begin_test();
    @(negedge axi_aclk);
    rate_shift = '0;
    m_tready   = 1'b0;
    // Let the 40-cycle gap of the last packet run out
    repeat (48) @(negedge axi_aclk);
    wr_start = wr_count;
    fork
      send_packet(5);
      begin
        n = 0;
        while (s_tready && n < wait_limit) begin
          @(negedge axi_aclk);
          n++;
        end
        if (s_tready) begin
          report_failure("s_tready stayed high with the output stalled");
        end else if (wr_count - wr_start != 3) begin
          report_mismatch("buffered word count", 3, wr_count - wr_start);
        end
        // Stall at the packet start, then once mid-packet
        repeat (5) @(negedge axi_aclk);
        m_tready = 1'b1;
        repeat (2) @(negedge axi_aclk);
        m_tready = 1'b0;
        repeat (4) @(negedge axi_aclk);
        m_tready = 1'b1;
      end
    join
    go_idle();
    wait_drain();
    end_test("back-pressure");
  endtask

  task automatic test_soft_reset();
    begin_test();
    @(negedge axi_aclk);
    rate_shift = rate_limiter_pkg::shift_width'(3);
    m_tready   = 1'b1;
    send_packet(4);
    go_idle();
    wait_drain();
    // 32-cycle gap now running, buffer nearly full behind it
    send_packet(3);
    go_idle();
    #1;
    if (m_tvalid !== 1'b0) report_mismatch("m_tvalid", 0, m_tvalid);
    if (s_tready !== 1'b0) report_mismatch("s_tready", 0, s_tready);
    @(negedge axi_aclk);
    sw_rst = 1'b1;
    @(negedge axi_aclk);
    sw_rst   = 1'b0;
    m_tready = 1'b0;
    exp_q.delete();
    gap_wait = 1'b0;
    #1;
    if (m_tvalid !== 1'b0) report_mismatch("m_tvalid", 0, m_tvalid);
    if (s_tready !== 1'b1) report_mismatch("s_tready", 1, s_tready);
    send_packet(2);
    go_idle();
    #1;
    if (m_tvalid !== 1'b1) report_failure("new packet held back by a gap from before the reset");
    @(negedge axi_aclk);
    m_tready = 1'b1;
    wait_drain();
    end_test("soft reset");
  endtask

  initial begin
    void'($urandom(32'h8cf7_0764));
    arst_n     = 1'b0;
    sw_rst     = 1'b0;
    rate_en    = 1'b0;
    rate_shift = '0;
    s_tdata    = '0;
    s_tstrb    = '0;
    s_tuser    = '0;
    s_tlast    = 1'b0;
    s_tvalid   = 1'b0;
    m_tready   = 1'b0;
    repeat (4) @(posedge axi_aclk);
    @(negedge axi_aclk);
    arst_n = 1'b1;
    test_bypass();
    test_integrity();
    test_gap_length();
    test_back_pressure();
    test_soft_reset();
    $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count, err_count);
    if (fail_count == 0 && err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== project.f ====
source/rate_limiter_pkg.sv
source/axis_if.sv
source/stream_fifo.sv
source/gap_timer.sv
source/egress_gate.sv
source/rate_limiter.sv
tests/rate_limiter_tb.sv
